// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - logic/isa_pkg.sv
  - logic/fetch_pkg.sv
  - logic/fetch_pc_gen.sv
  - logic/insn_buffer.sv
  - logic/decode_front.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - verif/fetch_sva.sv
      - verif/fetch_tb.sv

// ==== logic/decode_front.sv ====
// first decode register; only jump-format words get a target, error words become a NOP
`default_nettype none

module decode_front (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    flush_i,
   input  wire logic                    padv_i,
   input  wire logic                    valid_i,
   input  wire fetch_pkg::fetch_entry_t head_i,
   output logic                         pop_o,
   output fetch_pkg::decode_t           decode_o
);

   fetch_pkg::decode_t dec_q;
   fetch_pkg::decode_t dec_d;

   isa_pkg::insn_u word;
   logic           jump_opc;

   // take the head only when the pipeline moves and nothing is being flushed
   assign pop_o = padv_i & valid_i & ~flush_i;

   // bus error replaces the word so nothing downstream acts on garbage
   assign word = head_i.err ? isa_pkg::insn_u'(isa_pkg::NOP_WORD)
                            : isa_pkg::insn_u'(head_i.insn);

   assign jump_opc = (word.j.opcode == isa_pkg::OPC_J) ||
                     (word.j.opcode == isa_pkg::OPC_JAL);

   // next decode record, from the head entry
   always_comb
   begin
      dec_d.valid   = valid_i;
      dec_d.pc      = head_i.pc;
      dec_d.insn    = word;
      dec_d.err     = head_i.err;
      // early register-file read addresses, reg view
      dec_d.rfa     = word.r.ra;
      dec_d.rfb     = word.r.rb;
      dec_d.is_jump = jump_opc & ~head_i.err;
      // word offset, sign-extended and scaled to bytes
      dec_d.jump_target = head_i.pc +
                          {{4{word.j.offset[25]}}, word.j.offset, 2'b00};
   end

   // valid bit, cleared by reset and flush
   always_ff @(posedge clk)
   begin
      if (rst || flush_i)
      begin
         dec_q.valid <= 1'b0;
      end
      else if (padv_i)
      begin
         // pipeline moved on: either a new word or a bubble
         dec_q.valid <= dec_d.valid;
      end
   end

   // payload holds without padv
   always_ff @(posedge clk)
   begin
      if (pop_o)
      begin
         dec_q.pc          <= dec_d.pc;
         dec_q.insn        <= dec_d.insn;
         dec_q.err         <= dec_d.err;
         dec_q.rfa         <= dec_d.rfa;
         dec_q.rfb         <= dec_d.rfb;
         dec_q.is_jump     <= dec_d.is_jump;
         dec_q.jump_target <= dec_d.jump_target;
      end
   end

   assign decode_o = dec_q;

endmodule

`default_nettype wire

// ==== logic/fetch_pc_gen.sv ====
// one outstanding fetch at a time; the buffer must have room when a request starts
`default_nettype none

module fetch_pc_gen #(
   parameter fetch_pkg::addr_t RESET_PC = 32'h0000_0100
) (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   redirect_i,
   input  wire fetch_pkg::addr_t       redirect_pc_i,
   input  wire fetch_pkg::ibus_rsp_t   ibus_rsp_i,
   input  wire logic                   space_i,
   output fetch_pkg::ibus_req_t        ibus_req_o,
   output logic                        enq_o,
   output fetch_pkg::fetch_entry_t     enq_entry_o
);

   // fetch address, also the pc of the word in flight
   fetch_pkg::addr_t pc_q;

   // a request was raised and has not been answered yet
   logic busy_q;

   logic req;
   logic rsp_done;

   // request stays up while outstanding
   // a new one only starts when the buffer can take it
   assign req = busy_q | space_i;

   // ack or err ends the current access
   assign rsp_done = req & (ibus_rsp_i.ack | ibus_rsp_i.err);

   assign ibus_req_o.req = req;
   assign ibus_req_o.adr = pc_q;

   // hand the word on at the response edge
   // a redirect in the same cycle makes it stale, so drop it
   assign enq_o = rsp_done & ~redirect_i;

   assign enq_entry_o.pc   = pc_q;
   assign enq_entry_o.insn = ibus_rsp_i.dat;
   assign enq_entry_o.err  = ibus_rsp_i.err;

   // pc register
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc_q <= RESET_PC;
      end
      else if (redirect_i)
      begin
         // redirect wins over a coinciding response
         pc_q <= redirect_pc_i;
      end
      else if (rsp_done)
      begin
         pc_q <= pc_q + 32'd4;
      end
   end

   // outstanding flag
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy_q <= 1'b0;
      end
      else if (redirect_i)
      begin
         // buffer is flushed at this edge, so space holds req up for the target
         busy_q <= 1'b1;
      end
      else if (rsp_done)
      begin
         // next fetch waits for space, seen from the next cycle on
         busy_q <= 1'b0;
      end
      else if (req)
      begin
         busy_q <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
// bus and pipeline records for the fetch front end; byte addresses, word-aligned fetches only
`default_nettype none

package fetch_pkg;

   // byte address on the instruction bus
   typedef logic [31:0] addr_t;

   // request from the core, a level held until ack or err
   typedef struct packed {
      logic  req;
      addr_t adr;
   } ibus_req_t;

   // response from memory, single-cycle pulses
   // ack and err are never both set
   typedef struct packed {
      logic            ack;
      logic            err;
      isa_pkg::insn_w_t dat;
   } ibus_rsp_t;

   // one fetched word waiting in the buffer
   typedef struct packed {
      addr_t            pc;
      isa_pkg::insn_w_t insn;
      logic             err;
   } fetch_entry_t;

   // registered decode front output
   typedef struct packed {
      logic             valid;
      addr_t            pc;
      isa_pkg::insn_w_t insn;
      logic             err;
      isa_pkg::rf_adr_t rfa;
      isa_pkg::rf_adr_t rfb;
      logic             is_jump;
      addr_t            jump_target;
   } decode_t;

endpackage

`default_nettype wire

// ==== logic/fetch_top.sv ====
// fetch front end; redirect_i must already merge branch, exception and debug restart
`default_nettype none

module fetch_top #(
   parameter fetch_pkg::addr_t RESET_PC  = 32'h0000_0100,
   parameter int unsigned      BUF_DEPTH = 2
) (
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  redirect_i,
   input  wire fetch_pkg::addr_t      redirect_pc_i,
   input  wire logic                  padv_i,
   input  wire fetch_pkg::ibus_rsp_t  ibus_rsp_i,
   output fetch_pkg::ibus_req_t       ibus_req_o,
   output fetch_pkg::decode_t         decode_o
);

   // producer to buffer
   logic                    enq;
   fetch_pkg::fetch_entry_t enq_entry;
   logic                    space;

   // buffer to consumer
   logic                    head_valid;
   fetch_pkg::fetch_entry_t head;
   logic                    pop;

   // pc generator and bus request
   fetch_pc_gen #(
      .RESET_PC (RESET_PC)
   ) u_pc_gen (
      .clk           (clk),
      .rst           (rst),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .ibus_rsp_i    (ibus_rsp_i),
      .space_i       (space),
      .ibus_req_o    (ibus_req_o),
      .enq_o         (enq),
      .enq_entry_o   (enq_entry)
   );

   // words wait here while the pipeline stalls
   insn_buffer #(
      .BUF_DEPTH (BUF_DEPTH)
   ) u_buffer (
      .clk         (clk),
      .rst         (rst),
      .flush_i     (redirect_i),
      .enq_i       (enq),
      .enq_entry_i (enq_entry),
      .pop_i       (pop),
      .space_o     (space),
      .valid_o     (head_valid),
      .head_o      (head)
   );

   // decode register
   decode_front u_decode (
      .clk      (clk),
      .rst      (rst),
      .flush_i  (redirect_i),
      .padv_i   (padv_i),
      .valid_i  (head_valid),
      .head_i   (head),
      .pop_o    (pop),
      .decode_o (decode_o)
   );

endmodule

`default_nettype wire

// ==== logic/insn_buffer.sv ====
// circular FIFO of fetched words; BUF_DEPTH of 1 or more, head is read combinationally
`default_nettype none

module insn_buffer #(
   parameter int unsigned BUF_DEPTH = 2
) (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    flush_i,
   input  wire logic                    enq_i,
   input  wire fetch_pkg::fetch_entry_t enq_entry_i,
   input  wire logic                    pop_i,
   output logic                         space_o,
   output logic                         valid_o,
   output fetch_pkg::fetch_entry_t      head_o
);

   localparam int unsigned PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST = PTR_W'(BUF_DEPTH - 1);

   fetch_pkg::fetch_entry_t mem [BUF_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;

   logic do_enq;
   logic do_pop;

   assign valid_o = (count_q != '0);
   assign space_o = (count_q < CNT_W'(BUF_DEPTH));
   assign head_o  = mem[rd_ptr_q];

   // guarded, although the fetcher never enqueues into a full buffer
   assign do_enq = enq_i & space_o;
   assign do_pop = pop_i & valid_o;

   // entry storage
   always_ff @(posedge clk)
   begin
      if (do_enq)
      begin
         mem[wr_ptr_q] <= enq_entry_i;
      end
   end

   // pointers and fill level
   always_ff @(posedge clk)
   begin
      if (rst || flush_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (do_enq)
         begin
            wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
         end
         // simultaneous enqueue and pop leaves the count alone
         if (do_enq && !do_pop)
         begin
            count_q <= count_q + 1'b1;
         end
         else if (do_pop && !do_enq)
         begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
// instruction word layouts for fetch and early decode only; a NOP here is all-zero below the opcode
`default_nettype none

package isa_pkg;

   // raw 32-bit instruction as it comes off the bus
   typedef logic [31:0] insn_w_t;

   // register-file address, 32 registers
   typedef logic [4:0] rf_adr_t;

   // major opcode field, top six bits of every word
   typedef logic [5:0] opcode_t;

   // unconditional jump and jump-and-link use the jump view
   localparam opcode_t OPC_J   = 6'h00;
   localparam opcode_t OPC_JAL = 6'h01;

   // no-operation, also what decode sees after a bus error
   localparam opcode_t OPC_NOP  = 6'h05;
   localparam insn_w_t NOP_WORD = {OPC_NOP, 26'd0};

   // register format
   // rest holds immediates or function bits, not used by fetch
   typedef struct packed {
      opcode_t     opcode;
      rf_adr_t     rd;
      rf_adr_t     ra;
      rf_adr_t     rb;
      logic [10:0] rest;
   } insn_reg_t;

   // jump format
   // offset counts words, relative to the jump's own pc
   typedef struct packed {
      opcode_t            opcode;
      logic signed [25:0] offset;
   } insn_jump_t;

   // one word, two ways of reading it
   typedef union packed {
      insn_reg_t  r;
      insn_jump_t j;
   } insn_u;

endpackage

`default_nettype wire

// ==== project.f ====
logic/isa_pkg.sv
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/insn_buffer.sv
logic/decode_front.sv
logic/fetch_top.sv
verif/fetch_sva.sv
verif/fetch_tb.sv

// ==== verif/fetch_sva.sv ====
// checks for fetch_top, bound in; fail_count is polled by the testbench every cycle
`default_nettype none

module fetch_sva (
   input wire logic                 clk,
   input wire logic                 rst,
   input wire logic                 redirect_i,
   input wire fetch_pkg::ibus_req_t ibus_req_i,
   input wire fetch_pkg::ibus_rsp_t ibus_rsp_i,
   input wire fetch_pkg::decode_t   decode_i,
   input wire logic                 enq_i,
   input wire logic                 pop_i
);

   int unsigned fail_count = 0;

   // buffer fill level rebuilt from the enqueue and pop strobes
   logic [2:0] level_q;

   always_ff @(posedge clk)
   begin
      if (rst || redirect_i)
      begin
         level_q <= '0;
      end
      else
      begin
         level_q <= level_q + 3'(enq_i) - 3'(pop_i);
      end
   end

   // address holds until the access ends or a redirect moves it
   a_adr_stable : assert property (@(posedge clk) disable iff (rst)
      ibus_req_i.req && !ibus_rsp_i.ack && !ibus_rsp_i.err && !redirect_i
      |=> ibus_req_i.req && $stable(ibus_req_i.adr))
   else
   begin
      fail_count++;
      $error("bus address moved while a request was pending");
   end

   // memory side never answers both ways at once
   a_ack_err : assert property (@(posedge clk) !(ibus_rsp_i.ack && ibus_rsp_i.err))
   else
   begin
      fail_count++;
      $error("ack and err high together");
   end

   // first cycle out of reset is quiet
   a_reset_state : assert property (@(posedge clk) $fell(rst) |-> !decode_i.valid && !enq_i)
   else
   begin
      fail_count++;
      $error("decode valid or enqueue right after reset");
   end

   // pop only with something buffered
   a_pop_empty : assert property (@(posedge clk) disable iff (rst) pop_i |-> level_q != 3'd0)
   else
   begin
      fail_count++;
      $error("pop from an empty buffer");
   end

endmodule

bind fetch_top fetch_sva u_sva (
   .clk          (clk),
   .rst          (rst),
   .redirect_i   (redirect_i),
   .ibus_req_i   (ibus_req_o),
   .ibus_rsp_i   (ibus_rsp_i),
   .decode_i     (decode_o),
   .enq_i        (enq),
   .pop_i        (pop)
);

`default_nettype wire

// ==== verif/fetch_tb.sv ====
// fetch testbench for BUF_DEPTH 2; memory is a function of the address with one err window
`default_nettype none

module fetch_tb;

   localparam fetch_pkg::addr_t RESET_PC = 32'h0000_0100;
   localparam fetch_pkg::addr_t ERR_LO   = 32'h0000_2000;
   localparam fetch_pkg::addr_t ERR_HI   = 32'h0000_2010;

   // idle cycles before the redirect, its target, err expected on the target word,
   // and whether the redirect lands in the cycle of a bus response
   typedef struct packed {
      logic [7:0]       wait_cyc;
      fetch_pkg::addr_t target;
      logic             exp_err;
      logic             on_rsp;
   } redirect_row_t;

   localparam redirect_row_t REDIRECTS [6] = '{
      '{8'd30, 32'h0000_0400, 1'b0, 1'b0},
      '{8'd12, 32'h0000_1ff8, 1'b0, 1'b0},
      '{8'd3,  32'h0000_2004, 1'b1, 1'b1},
      '{8'd1,  32'h0000_0a00, 1'b0, 1'b1},
      '{8'd25, 32'h0000_200c, 1'b1, 1'b0},
      '{8'd2,  32'h0000_0e3c, 1'b0, 1'b1}
   };

   logic                 clk = 1'b0;
   logic                 rst = 1'b1;
   logic                 redirect = 1'b0;
   fetch_pkg::addr_t     redirect_pc = '0;
   logic                 padv = 1'b0;
   fetch_pkg::ibus_rsp_t ibus_rsp = '0;
   fetch_pkg::ibus_req_t ibus_req;
   fetch_pkg::decode_t   decode;

   // responder state
   logic [31:0]          rng = 32'h4f7566c5;
   logic                 hold_adv = 1'b0;
   logic                 tracked = 1'b0;
   fetch_pkg::addr_t     tracked_adr = '0;
   logic [1:0]           wait_cnt = '0;
   // reference model state
   logic                 adv_prev = 1'b0;
   fetch_pkg::addr_t     exp_pc = RESET_PC;
   int unsigned          dec_count = 0;
   fetch_pkg::decode_t   last_dec = '0;

   fetch_top #(
      .RESET_PC  (RESET_PC),
      .BUF_DEPTH (2)
   ) u_dut (
      .clk           (clk),
      .rst           (rst),
      .redirect_i    (redirect),
      .redirect_pc_i (redirect_pc),
      .padv_i        (padv),
      .ibus_rsp_i    (ibus_rsp),
      .ibus_req_o    (ibus_req),
      .decode_o      (decode)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic in_err_window(input fetch_pkg::addr_t a);
      return (a >= ERR_LO) && (a < ERR_HI);
   endfunction

   // every eighth word jumps, direction from bit 9; the rest are reg format
   function automatic isa_pkg::insn_w_t mem_word(input fetch_pkg::addr_t a);
      if (a[4:2] == 3'd7)
         return {a[5] ? isa_pkg::OPC_JAL : isa_pkg::OPC_J, {18{a[9]}}, a[9:2]};
      return {3'b100, a[4:2], a[6:2], a[11:7], a[16:12], a[27:17]};
   endfunction

   // expected decode record by the format rules
   function automatic fetch_pkg::decode_t expect_decode(input fetch_pkg::addr_t pc,
                                                        input logic err);
      fetch_pkg::decode_t d;
      isa_pkg::insn_w_t   w;
      w = err ? isa_pkg::NOP_WORD : mem_word(pc);
      d.valid = 1'b1;
      d.pc    = pc;
      d.insn  = w;
      d.err   = err;
      // ra in 20:16, rb in 15:11
      d.rfa     = w[20:16];
      d.rfb     = w[15:11];
      d.is_jump = !err && (w[31:26] == isa_pkg::OPC_J || w[31:26] == isa_pkg::OPC_JAL);
      // signed word offset, turned into bytes
      d.jump_target = pc + (32'(signed'(w[25:0])) << 2);
      return d;
   endfunction

   task automatic abort_run();
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_req(input fetch_pkg::ibus_req_t got, input fetch_pkg::ibus_req_t exp);
      if (got.req !== exp.req || (exp.req && got.adr !== exp.adr))
      begin
         $display("ERR %0t: ibus req %0b adr %h, expected req %0b adr %h",
                  $time, got.req, got.adr, exp.req, exp.adr);
         abort_run();
      end
   endtask

   task automatic check_decode(input fetch_pkg::decode_t got, input fetch_pkg::decode_t exp);
      logic bad;
      bad = (got.valid !== exp.valid);
      // payload only matters for a valid record, target only for jumps
      if (exp.valid)
         bad = bad || got.pc !== exp.pc || got.insn !== exp.insn || got.err !== exp.err
               || got.rfa !== exp.rfa || got.rfb !== exp.rfb || got.is_jump !== exp.is_jump
               || (exp.is_jump && got.jump_target !== exp.jump_target);
      if (bad)
      begin
         $display("ERR %0t: decode v%0b pc %h insn %h err %0b rf %0d/%0d j%0b tgt %h", $time,
                  got.valid, got.pc, got.insn, got.err, got.rfa, got.rfb, got.is_jump,
                  got.jump_target);
         $display("ERR %0t: expected v%0b pc %h insn %h err %0b rf %0d/%0d j%0b tgt %h", $time,
                  exp.valid, exp.pc, exp.insn, exp.err, exp.rfa, exp.rfb, exp.is_jump,
                  exp.jump_target);
         abort_run();
      end
   endtask

   always @(posedge clk)
   begin
      if (u_dut.u_sva.fail_count != 0)
      begin
         $display("a bound assertion failed, see the message above");
         abort_run();
      end
   end

   // random padv and the memory responder
   always @(posedge clk)
   begin
      logic [1:0] wait_v;
      rng = xorshift(rng);
      padv <= !rst && !hold_adv && ((rng % 32'd10) < 32'd6);
      ibus_rsp <= '0;
      if (rst || ibus_rsp.ack || ibus_rsp.err || redirect)
      begin
         // address moves at this edge, latency starts over
         tracked <= 1'b0;
      end
      else if (ibus_req.req)
      begin
         if (!tracked || ibus_req.adr != tracked_adr)
         begin
            rng = xorshift(rng);
            wait_v = rng[1:0];
            tracked     <= 1'b1;
            tracked_adr <= ibus_req.adr;
         end
         else
            wait_v = wait_cnt;
         if (wait_v == 2'd0)
         begin
            ibus_rsp.ack <= !in_err_window(ibus_req.adr);
            ibus_rsp.err <= in_err_window(ibus_req.adr);
            ibus_rsp.dat <= mem_word(ibus_req.adr);
            tracked      <= 1'b0;
         end
         else
            wait_cnt <= wait_v - 2'd1;
      end
   end

   // reference model, a record is new when padv was high the cycle before
   always @(posedge clk)
   begin
      if (rst)
      begin
         exp_pc = RESET_PC;
         adv_prev <= 1'b0;
      end
      else
      begin
         if (decode.valid && adv_prev)
         begin
            check_decode(decode, expect_decode(exp_pc, in_err_window(exp_pc)));
            exp_pc = exp_pc + 32'd4;
            last_dec  <= decode;
            dec_count <= dec_count + 1;
         end
         // redirect restarts the expected stream
         if (redirect)
            exp_pc = redirect_pc;
         adv_prev <= padv;
      end
   end

   initial
   begin
      int unsigned n;
      int unsigned i;
      int unsigned base;
      for (n = 0; n < 16; n++)
         @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      // fetch at the reset vector, nothing decoded yet
      check_req(ibus_req, '{req: 1'b1, adr: RESET_PC});
      check_decode(decode, '0);
      for (n = 0; n < 400 && dec_count < 24; n++)
         @(posedge clk);
      if (dec_count < 24)
      begin
         $display("timeout: fewer than 24 words decoded after reset");
         abort_run();
      end
      // stall the pipeline, fetch must stop once the buffer is full
      hold_adv <= 1'b1;
      for (n = 0; n < 20 && ibus_req.req; n++)
         @(posedge clk);
      if (ibus_req.req)
      begin
         $display("timeout: fetch request still high with the pipeline stalled");
         abort_run();
      end
      while (n < 20)
      begin
         @(posedge clk);
         n++;
      end
      check_req(ibus_req, '{req: 1'b0, adr: '0});
      hold_adv <= 1'b0;
      for (i = 0; i < 6; i++)
      begin
         for (n = 0; n < REDIRECTS[i].wait_cyc; n++)
            @(posedge clk);
         // the responder answers at this edge when its countdown has run out
         if (REDIRECTS[i].on_rsp)
         begin
            for (n = 0; n < 40 && !(tracked && wait_cnt == 2'd0); n++)
               @(posedge clk);
            if (!(tracked && wait_cnt == 2'd0))
            begin
               $display("timeout: no bus response lined up for redirect to %h",
                        REDIRECTS[i].target);
               abort_run();
            end
         end
         redirect    <= 1'b1;
         redirect_pc <= REDIRECTS[i].target;
         @(posedge clk);
         redirect <= 1'b0;
         // a word decoded in the redirect cycle is counted by now
         @(posedge clk);
         base = dec_count;
         for (n = 0; n < 80 && dec_count == base; n++)
            @(posedge clk);
         if (dec_count == base)
         begin
            $display("timeout: nothing decoded after redirect to %h", REDIRECTS[i].target);
            abort_run();
         end
         check_decode(last_dec, expect_decode(REDIRECTS[i].target, REDIRECTS[i].exp_err));
      end
      base = dec_count;
      for (n = 0; n < 200 && dec_count < base + 8; n++)
         @(posedge clk);
      if (dec_count < base + 8)
      begin
         $display("timeout: fetch stalled after the last redirect");
         abort_run();
      end
      if (u_dut.u_sva.fail_count == 0)
      begin
         $display("No errors");
         $finish;
      end
      else
      begin
         $display("assertion failures: %0d", u_dut.u_sva.fail_count);
         abort_run();
      end
   end

endmodule

`default_nettype wire
